/* all.f */
+incdir+include
logic/bob_entry_pkg.sv
logic/bob_port_pkg.sv
logic/bob_entry_ram.sv
logic/bob_ring_ctrl.sv
logic/bob_done_tracker.sv
logic/bob_retire_unit.sv
logic/bob_top.sv
tests/bob_properties.sv
tests/bob_tb.sv

/* Bender.yml */
package:
  name: bob

sources:
  - include_dirs:
      - include
    files:
      - logic/bob_entry_pkg.sv
      - logic/bob_port_pkg.sv
      - logic/bob_entry_ram.sv
      - logic/bob_ring_ctrl.sv
      - logic/bob_done_tracker.sv
      - logic/bob_retire_unit.sv
      - logic/bob_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/bob_properties.sv
      - tests/bob_tb.sv

/* tests/bob_tb.sv */
`include "bob_macros.svh"

`default_nettype none

module bob_tb;

  import bob_entry_pkg::*;
  import bob_port_pkg::*;

  typedef struct packed {
    bob_idx_t             idx;
    logic [`BOB_PC_W-1:0] pc;
    logic                 pred_taken;
    logic [`BOB_PC_W-1:0] pred_target;
    logic                 resolved;
    logic                 act_taken;
    logic [`BOB_PC_W-1:0] act_target;
  } model_ent_t;

  logic         clk;
  logic         rst;
  bob_issue_t   issue;
  logic         alloc_ready;
  bob_idx_t     alloc_idx;
  bob_resolve_t resolve;
  logic         flush;
  bob_retire_t  retire;

  model_ent_t model_q[$]; // allocated branches, oldest first
  model_ent_t rep_ent;    // head of the model in the current cycle
  logic       rep_avail;
  logic       rep_misp;
  bob_idx_t   exp_alloc_idx;
  logic       pend_alloc;
  logic       exp_ready;
  integer     seed;
  integer     errors;
  integer     test_num;

  bob_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .issue       (issue),
    .alloc_ready (alloc_ready),
    .alloc_idx   (alloc_idx),
    .resolve     (resolve),
    .flush       (flush),
    .retire      (retire)
  );

  always #10 clk = ~clk;

  function automatic logic expect_mispredict(input model_ent_t e);
    if (e.act_taken != e.pred_taken) begin
      return 1'b1;
    end
    return e.act_taken && (e.act_target != e.pred_target); // taken both ways, wrong target
  endfunction

  a_report_expected: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> rep_avail)
    else begin
      $display("retire report seen while the oldest branch in the model is unresolved");
      errors++;
    end

  a_report_idx: assert property (@(posedge clk) disable iff (rst)
    retire.valid && rep_avail |-> retire.idx == rep_ent.idx)
    else begin
      $display("CHECK FAILED retire.idx got %h expected %h",
               $sampled(retire.idx), $sampled(rep_ent.idx));
      errors++;
    end

  a_report_pc: assert property (@(posedge clk) disable iff (rst)
    retire.valid && rep_avail |-> retire.pc == rep_ent.pc)
    else begin
      $display("CHECK FAILED retire.pc got %h expected %h",
               $sampled(retire.pc), $sampled(rep_ent.pc));
      errors++;
    end

  a_report_misp: assert property (@(posedge clk) disable iff (rst)
    retire.valid && rep_avail |-> retire.mispredict == rep_misp)
    else begin
      $display("CHECK FAILED retire.mispredict got %h expected %h",
               $sampled(retire.mispredict), $sampled(rep_misp));
      errors++;
    end

  a_report_target: assert property (@(posedge clk) disable iff (rst)
    retire.valid && rep_avail |-> retire.act_target == rep_ent.act_target)
    else begin
      $display("CHECK FAILED retire.act_target got %h expected %h",
               $sampled(retire.act_target), $sampled(rep_ent.act_target));
      errors++;
    end

  a_alloc_idx: assert property (@(posedge clk) disable iff (rst)
    alloc_idx == exp_alloc_idx)
    else begin
      $display("CHECK FAILED alloc_idx got %h expected %h",
               $sampled(alloc_idx), $sampled(exp_alloc_idx));
      errors++;
    end

  a_ready: assert property (@(posedge clk) disable iff (rst)
    alloc_ready == exp_ready)
    else begin
      $display("CHECK FAILED alloc_ready got %h expected %h",
               $sampled(alloc_ready), $sampled(exp_ready));
      errors++;
    end

  // falling edge: update the model, then clear the inputs for new stimulus
  task automatic next_cycle();
    @(negedge clk);
    if (pend_alloc) begin
      if (exp_alloc_idx == `BOB_COUNT - 1) begin
        exp_alloc_idx = '0;
      end else begin
        exp_alloc_idx = exp_alloc_idx + 1'b1;
      end
      pend_alloc = 1'b0;
    end
    rep_avail = 1'b0;
    if (model_q.size() > 0) begin
      rep_ent = model_q[0];
      rep_avail = model_q[0].resolved;
      rep_misp = expect_mispredict(model_q[0]);
    end
    if (retire.valid === 1'b1 && model_q.size() > 0) begin
      void'(model_q.pop_front()); // reported this cycle
    end
    exp_ready = (model_q.size() < `BOB_COUNT);
    issue = '0;
    resolve = '0;
    flush = 1'b0;
  endtask

  task automatic send_issue(input logic [`BOB_PC_W-1:0] pc, input logic taken,
                            input logic [`BOB_PC_W-1:0] target);
    model_ent_t e;
    issue.valid = 1'b1;
    issue.rec.pc = pc;
    issue.rec.pred_taken = taken;
    issue.rec.pred_target = target;
    if (model_q.size() < `BOB_COUNT) begin
      e = '0;
      e.idx = exp_alloc_idx;
      e.pc = pc;
      e.pred_taken = taken;
      e.pred_target = target;
      model_q.push_back(e);
      pend_alloc = 1'b1;
    end
  endtask

  task automatic resolve_mixed(input int pos);
    integer r;
    logic [`BOB_PC_W-1:0] target;
    r = $random(seed);
    if (r[1]) begin
      target = model_q[pos].pred_target;
    end else begin
      target = model_q[pos].pc + {r[11:4], 2'b00};
    end
    resolve.valid = 1'b1;
    resolve.idx = model_q[pos].idx;
    resolve.rec.act_taken = r[0];
    resolve.rec.act_target = target;
    model_q[pos].resolved = 1'b1;
    model_q[pos].act_taken = r[0];
    model_q[pos].act_target = target;
  endtask

  task automatic resolve_stale(input bob_idx_t idx);
    resolve.valid = 1'b1;
    resolve.idx = idx;
    resolve.rec.act_taken = 1'b1;
    resolve.rec.act_target = 32'h0000_0100;
  endtask

  task automatic send_flush();
    flush = 1'b1;
    model_q.delete(); // everything unreported is dropped
  endtask

  function automatic int find_unresolved(input logic from_back);
    int p;
    p = -1;
    foreach (model_q[i]) begin
      if (!model_q[i].resolved && (from_back || p < 0)) begin
        p = i;
      end
    end
    return p;
  endfunction

  function automatic int pick_unresolved(input int r);
    int cnt;
    int k;
    cnt = 0;
    foreach (model_q[i]) begin
      if (!model_q[i].resolved) begin
        cnt++;
      end
    end
    if (cnt == 0) begin
      return -1;
    end
    k = r % cnt;
    foreach (model_q[i]) begin
      if (!model_q[i].resolved) begin
        if (k == 0) begin
          return i;
        end
        k--;
      end
    end
    return -1;
  endfunction

  task automatic retire_everything(input int limit);
    int n;
    int p;
    n = 0;
    while (model_q.size() > 0 && n < limit) begin
      next_cycle();
      p = find_unresolved(1'b0);
      if (p >= 0) begin
        resolve_mixed(p);
      end
      n++;
    end
    if (model_q.size() > 0) begin
      $display("timeout: %0d branches still waiting to retire", model_q.size());
      errors++;
    end
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (!alloc_ready && n < limit) begin
      next_cycle();
      n++;
    end
    if (!alloc_ready) begin
      $display("timeout: alloc_ready stayed low after a retire from a full buffer");
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %0d %s done, %0d errors so far", test_num, name,
             errors + dut0.u_props.fail_count);
    test_num++;
  endtask

  initial begin
    int i;
    int p;
    integer r;
    bob_idx_t stale [4];
    clk = 1'b0;
    rst = 1'b1;
    issue = '0;
    resolve = '0;
    flush = 1'b0;
    seed = 41;
    errors = 0;
    test_num = 1;
    exp_alloc_idx = '0;
    pend_alloc = 1'b0;
    exp_ready = 1'b1;
    rep_avail = 1'b0;
    rep_ent = '0;
    rep_misp = 1'b0;
    repeat (4) next_cycle();
    rst = 1'b0;

    for (i = 0; i < 5; i++) begin
      next_cycle();
      send_issue(32'h1000 + i * 4, i[0], 32'h2000 + i * 16);
    end
    for (i = 0; i < 5; i++) begin
      next_cycle();
      resolve_mixed(find_unresolved(1'b0));
    end
    retire_everything(50);
    finish_test("in-order retire");

    for (i = 0; i < 5; i++) begin
      next_cycle();
      send_issue(32'h3000 + i * 4, 1'b1, 32'h3800 + i * 8);
    end
    for (i = 0; i < 5; i++) begin
      next_cycle();
      resolve_mixed(find_unresolved(1'b1)); // youngest first
      repeat (2) next_cycle();
    end
    retire_everything(50);
    finish_test("out-of-order resolve");

    for (i = 0; i < `BOB_COUNT; i++) begin
      next_cycle();
      send_issue($random(seed), 1'b0, 32'h0);
    end
    next_cycle();
    send_issue(32'hdead_0000, 1'b1, 32'h40); // must be ignored
    next_cycle();
    send_issue(32'hdead_0004, 1'b0, 32'h44);
    next_cycle();
    resolve_mixed(0);
    wait_ready(8);
    retire_everything(200);
    finish_test("full buffer");

    for (i = 0; i < 4; i++) begin
      next_cycle();
      send_issue(32'h5000 + i * 4, 1'b1, 32'h6000);
    end
    repeat (2) next_cycle();
    for (i = 0; i < 4; i++) begin
      stale[i] = model_q[i].idx;
    end
    send_flush();
    for (i = 0; i < 4; i++) begin
      next_cycle();
      resolve_stale(stale[i]);
    end
    repeat (6) next_cycle();
    send_issue(32'h7000, 1'b0, 32'h7100);
    retire_everything(50);
    finish_test("flush");

    for (i = 0; i < 60; i++) begin
      next_cycle();
      send_issue($random(seed), i[1], $random(seed));
      next_cycle();
      p = find_unresolved(1'b0);
      if (p >= 0) begin
        resolve_mixed(p);
      end
    end
    retire_everything(50);
    finish_test("wraparound");

    for (i = 0; i < 300; i++) begin
      next_cycle();
      r = $random(seed);
      if (r[5:0] == 6'd0) begin
        send_flush();
      end else begin
        p = pick_unresolved(int'(r[15:8]));
        if (r[1] && p >= 0) begin
          resolve_mixed(p);
        end
        if (r[2]) begin
          send_issue($random(seed), r[3], $random(seed));
        end
      end
    end
    retire_everything(200);
    finish_test("random mix");

    repeat (3) next_cycle();
    $display("summary: %0d tests, %0d testbench errors, %0d property errors",
             test_num - 1, errors, dut0.u_props.fail_count);
    if (errors == 0 && dut0.u_props.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/bob_properties.sv */
`include "bob_macros.svh"

`default_nettype none

module bob_properties (
  input logic                    clk,
  input logic                    rst,
  input logic                    retire_valid,
  input logic                    do_retire,
  input logic                    alloc_ready,
  input bob_entry_pkg::bob_idx_t alloc_idx,
  input bob_entry_pkg::bob_idx_t retire_idx
);

  int fail_count; // failed assertions so far

  initial fail_count = 0;

  a_quiet_after_reset: assert property (@(posedge clk) rst |=> !retire_valid)
    else begin
      $error("retire valid high in the cycle after reset");
      fail_count++;
    end

  a_report_follows_retire: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> $past(do_retire))
    else begin
      $error("retire report without a retire decision one cycle earlier");
      fail_count++;
    end

  a_retire_gives_report: assert property (@(posedge clk) disable iff (rst)
    do_retire |=> retire_valid)
    else begin
      $error("retire decision not followed by a report");
      fail_count++;
    end

  a_alloc_idx_range: assert property (@(posedge clk) disable iff (rst)
    alloc_idx < `BOB_COUNT)
    else begin
      $error("allocate pointer left the ring");
      fail_count++;
    end

  a_retire_idx_range: assert property (@(posedge clk) disable iff (rst)
    retire_idx < `BOB_COUNT)
    else begin
      $error("retire pointer left the ring");
      fail_count++;
    end

  // a full ring means the allocate pointer has come round to the retire pointer
  a_ready_only_full: assert property (@(posedge clk) disable iff (rst)
    !alloc_ready |-> alloc_idx == retire_idx)
    else begin
      $error("alloc ready low with free slots left");
      fail_count++;
    end

endmodule

bind bob_top bob_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .retire_valid (retire.valid),
  .do_retire    (do_retire),
  .alloc_ready  (alloc_ready),
  .alloc_idx    (alloc_idx),
  .retire_idx   (retire_idx)
);

`default_nettype wire

/* logic/bob_top.sv */
`default_nettype none

module bob_top (
  input  logic                       clk,
  input  logic                       rst,
  input  bob_port_pkg::bob_issue_t   issue,
  output logic                       alloc_ready,
  output bob_entry_pkg::bob_idx_t    alloc_idx,
  input  bob_port_pkg::bob_resolve_t resolve,
  input  logic                       flush,
  output bob_port_pkg::bob_retire_t  retire
);

  import bob_entry_pkg::*;

  logic             alloc_fire;
  logic             has_entry;
  logic             head_done;
  logic             do_retire;
  bob_idx_t         retire_idx;
  bob_issue_rec_t   issue_rec_rd;
  bob_resolve_rec_t resolve_rec_rd;

  bob_ring_ctrl u_ring (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .issue_valid (issue.valid),
    .alloc_ready (alloc_ready),
    .alloc_fire  (alloc_fire),
    .alloc_idx   (alloc_idx),
    .do_retire   (do_retire),
    .has_entry   (has_entry),
    .retire_idx  (retire_idx)
  );

  // pc and prediction, written at allocate
  bob_entry_ram #(
    .payload_t (bob_issue_rec_t)
  ) u_issue_ram (
    .clk        (clk),
    .read_en    (1'b1),
    .read_addr  (retire_idx),
    .read_data  (issue_rec_rd),
    .write_en   (alloc_fire),
    .write_addr (alloc_idx),
    .write_data (issue.rec)
  );

  // actual outcome, written at resolve
  bob_entry_ram #(
    .payload_t (bob_resolve_rec_t)
  ) u_resolve_ram (
    .clk        (clk),
    .read_en    (1'b1),
    .read_addr  (retire_idx),
    .read_data  (resolve_rec_rd),
    .write_en   (resolve.valid),
    .write_addr (resolve.idx),
    .write_data (resolve.rec)
  );

  bob_done_tracker u_done (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .alloc_fire    (alloc_fire),
    .alloc_idx     (alloc_idx),
    .resolve_valid (resolve.valid),
    .resolve_idx   (resolve.idx),
    .retire_idx    (retire_idx),
    .head_done     (head_done)
  );

  bob_retire_unit u_retire (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .has_entry   (has_entry),
    .head_done   (head_done),
    .retire_idx  (retire_idx),
    .issue_rec   (issue_rec_rd),
    .resolve_rec (resolve_rec_rd),
    .do_retire   (do_retire),
    .retire      (retire)
  );

endmodule

`default_nettype wire

/* logic/bob_retire_unit.sv */
`default_nettype none

module bob_retire_unit (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush,
  input  logic                            has_entry,
  input  logic                            head_done,
  input  bob_entry_pkg::bob_idx_t         retire_idx,
  input  bob_entry_pkg::bob_issue_rec_t   issue_rec,
  input  bob_entry_pkg::bob_resolve_rec_t resolve_rec,
  output logic                            do_retire,
  output bob_port_pkg::bob_retire_t       retire
);

  import bob_entry_pkg::*;

  logic     ret_valid_q;
  bob_idx_t ret_idx_q;
  logic     dir_wrong;
  logic     target_wrong;

  // oldest branch leaves once its outcome is known
  assign do_retire = has_entry && head_done && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid_q <= 1'b0;
    end else begin
      ret_valid_q <= do_retire; // a flush does not cancel a report in progress
    end
  end

  always_ff @(posedge clk) begin
    if (do_retire) begin
      ret_idx_q <= retire_idx;
    end
  end

  // RAM address was captured at the same edge, so the records belong to ret_idx_q
  assign dir_wrong = (resolve_rec.act_taken != issue_rec.pred_taken);
  assign target_wrong = resolve_rec.act_taken && issue_rec.pred_taken &&
                        (resolve_rec.act_target != issue_rec.pred_target);

  assign retire.valid = ret_valid_q;
  assign retire.idx = ret_idx_q;
  assign retire.pc = issue_rec.pc;
  assign retire.mispredict = dir_wrong || target_wrong;
  assign retire.act_target = resolve_rec.act_target;

endmodule

`default_nettype wire

/* logic/bob_done_tracker.sv */
`include "bob_macros.svh"

`default_nettype none

module bob_done_tracker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush,
  input  logic                    alloc_fire,
  input  bob_entry_pkg::bob_idx_t alloc_idx,
  input  logic                    resolve_valid,
  input  bob_entry_pkg::bob_idx_t resolve_idx,
  input  bob_entry_pkg::bob_idx_t retire_idx,
  output logic                    head_done
);

  logic [`BOB_COUNT-1:0] done; // one resolved bit per slot

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      done <= '0;
    end else begin
      if (alloc_fire) begin
        done[alloc_idx] <= 1'b0; // fresh branch, not resolved yet
      end
      if (resolve_valid) begin
        done[resolve_idx] <= 1'b1;
      end
    end
  end

  assign head_done = done[retire_idx];

endmodule

`default_nettype wire

/* logic/bob_ring_ctrl.sv */
`include "bob_macros.svh"

`default_nettype none

module bob_ring_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush,
  input  logic                    issue_valid,
  output logic                    alloc_ready,
  output logic                    alloc_fire,
  output bob_entry_pkg::bob_idx_t alloc_idx,
  input  logic                    do_retire,
  output logic                    has_entry,
  output bob_entry_pkg::bob_idx_t retire_idx
);

  import bob_entry_pkg::*;

  localparam logic [`BOB_IDX_W:0] FULL_COUNT = `BOB_COUNT;
  localparam bob_idx_t LAST_IDX = `BOB_COUNT - 1;

  logic [`BOB_IDX_W:0] count; // branches between retire and allocate pointers

  function automatic bob_idx_t next_idx(input bob_idx_t idx);
    if (idx == LAST_IDX) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  assign alloc_ready = (count != FULL_COUNT);
  assign alloc_fire = issue_valid && alloc_ready && !flush;
  assign has_entry = (count != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_idx <= '0;
      retire_idx <= '0;
      count <= '0;
    end else if (flush) begin
      retire_idx <= alloc_idx; // drop everything still in flight
      count <= '0;
    end else begin
      if (alloc_fire) begin
        alloc_idx <= next_idx(alloc_idx);
      end
      if (do_retire) begin
        retire_idx <= next_idx(retire_idx);
      end
      // both at once leaves the count alone
      if (alloc_fire && !do_retire) begin
        count <= count + 1'b1;
      end else if (do_retire && !alloc_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/bob_entry_ram.sv */
`include "bob_macros.svh"

`default_nettype none

module bob_entry_ram #(
  parameter type payload_t = logic
) (
  input  logic                    clk,
  input  logic                    read_en,
  input  bob_entry_pkg::bob_idx_t read_addr,
  output payload_t                read_data,
  input  logic                    write_en,
  input  bob_entry_pkg::bob_idx_t write_addr,
  input  payload_t                write_data
);

  import bob_entry_pkg::*;

  payload_t mem [`BOB_COUNT];
  bob_idx_t read_addr_q;

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
    if (read_en) begin
      read_addr_q <= read_addr; // data shows up the cycle after
    end
  end

  assign read_data = mem[read_addr_q];

endmodule

`default_nettype wire

/* logic/bob_port_pkg.sv */
`include "bob_macros.svh"

`default_nettype none

package bob_port_pkg;

  import bob_entry_pkg::*;

  // one branch entering the buffer
  typedef struct packed {
    logic           valid;
    bob_issue_rec_t rec;
  } bob_issue_t;

  // outcome of a branch from an execution unit
  typedef struct packed {
    logic             valid;
    bob_idx_t         idx; // slot handed out at allocate
    bob_resolve_rec_t rec;
  } bob_resolve_t;

  // one retired branch, in program order
  typedef struct packed {
    logic                 valid;
    bob_idx_t             idx;
    logic [`BOB_PC_W-1:0] pc;
    logic                 mispredict;
    logic [`BOB_PC_W-1:0] act_target;
  } bob_retire_t;

endpackage

`default_nettype wire

/* logic/bob_entry_pkg.sv */
`include "bob_macros.svh"

`default_nettype none

package bob_entry_pkg;

  typedef logic [`BOB_IDX_W-1:0] bob_idx_t;

  // written into the issue RAM when a branch is allocated
  typedef struct packed {
    logic [`BOB_PC_W-1:0] pc;
    logic                 pred_taken;
    logic [`BOB_PC_W-1:0] pred_target;
  } bob_issue_rec_t;

  // written into the resolve RAM by the execution units
  typedef struct packed {
    logic                 act_taken;
    logic [`BOB_PC_W-1:0] act_target; // real next pc when taken
  } bob_resolve_rec_t;

endpackage

`default_nettype wire

/* include/bob_macros.svh */
`ifndef BOB_MACROS_SVH
`define BOB_MACROS_SVH

`default_nettype none

// ring geometry
`define BOB_COUNT 48 // branches in flight
`define BOB_IDX_W 6  // enough for BOB_COUNT slots

// branch addresses and targets
`define BOB_PC_W 32

`default_nettype wire

`endif
